// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_top
FILELIST = filelist.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit
(
    input  mips_pkg::opcode_e   i_opcode,
    output mips_pkg::ex_ctrl_t  o_ex,
    output mips_pkg::mem_ctrl_t o_mem,
    output mips_pkg::wb_ctrl_t  o_wb
);

    always_comb
    begin
        // Unknown opcodes fall through as no-ops
        o_ex  = '0;
        o_mem = '0;
        o_wb  = '0;
        case (i_opcode)
            mips_pkg::OP_RTYPE:
            begin
                o_ex.reg_dst    = 1'b1;
                o_ex.alu_op     = mips_pkg::ALUOP_FUNCT;
                o_wb.reg_write  = 1'b1;
            end
            mips_pkg::OP_ADDI:
            begin
                o_ex.alu_src    = 1'b1;
                o_ex.alu_op     = mips_pkg::ALUOP_ADD;
                o_wb.reg_write  = 1'b1;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI:
            begin
                o_ex.alu_src    = 1'b1;
                o_ex.alu_op     = mips_pkg::ALUOP_IMM;
                o_wb.reg_write  = 1'b1;
                o_wb.zero_extend = 1'b1;
            end
            mips_pkg::OP_SLTI:
            begin
                o_ex.alu_src    = 1'b1;
                o_ex.alu_op     = mips_pkg::ALUOP_IMM;
                o_wb.reg_write  = 1'b1;
            end
            mips_pkg::OP_LUI:
            begin
                o_ex.alu_src    = 1'b1;
                o_ex.alu_op     = mips_pkg::ALUOP_IMM;
                o_wb.reg_write  = 1'b1;
                o_wb.lui        = 1'b1;
            end
            mips_pkg::OP_LW:
            begin
                o_ex.alu_src    = 1'b1;
                o_ex.alu_op     = mips_pkg::ALUOP_ADD;
                o_mem.mem_read  = 1'b1;
                o_wb.mem_to_reg = 1'b1;
                o_wb.reg_write  = 1'b1;
            end
            mips_pkg::OP_SW:
            begin
                o_ex.alu_src    = 1'b1;
                o_ex.alu_op     = mips_pkg::ALUOP_ADD;
                o_mem.mem_write = 1'b1;
            end
            mips_pkg::OP_BEQ:
            begin
                o_ex.alu_op     = mips_pkg::ALUOP_SUB;
                o_mem.branch    = 1'b1;
            end
            mips_pkg::OP_BNE:
            begin
                o_ex.alu_op     = mips_pkg::ALUOP_SUB;
                o_mem.nbranch   = 1'b1;
            end
            mips_pkg::OP_J:
            begin
                o_ex.jump       = 1'b1;
            end
            mips_pkg::OP_JAL:
            begin
                o_ex.jump       = 1'b1;
                o_ex.jal        = 1'b1;
                o_wb.reg_write  = 1'b1;
            end
            mips_pkg::OP_HALT:
            begin
                o_wb.halt       = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module decode_stage
(
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire [`DATA_W-1:0]      i_instr,
    input  wire [`DATA_W-1:0]      i_pc4,
    input  wire                    i_wb_en,
    input  wire [`REG_ADDR_W-1:0]  i_wb_addr,
    input  wire [`DATA_W-1:0]      i_wb_data,
    output mips_pkg::id_ex_t       o_id_ex
);

    mips_pkg::ex_ctrl_t  ex_ctrl;
    mips_pkg::mem_ctrl_t mem_ctrl;
    mips_pkg::wb_ctrl_t  wb_ctrl;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [15:0]            imm;
    logic [`DATA_W-1:0]     rs_data;
    logic [`DATA_W-1:0]     rt_data;

    assign rs  = i_instr[25:21];
    assign rt  = i_instr[20:16];
    assign rd  = i_instr[15:11];
    assign imm = i_instr[15:0];

    control_unit u_control_unit
    (
        .i_opcode (mips_pkg::opcode_e'(i_instr[31:26])),
        .o_ex     (ex_ctrl),
        .o_mem    (mem_ctrl),
        .o_wb     (wb_ctrl)
    );

    register_file u_register_file
    (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rs_addr (rs),
        .i_rt_addr (rt),
        .i_wr_en   (i_wb_en),
        .i_wr_addr (i_wb_addr),
        .i_wr_data (i_wb_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    always_comb
    begin
        o_id_ex.pc4         = i_pc4;
        o_id_ex.instruction = i_instr;
        o_id_ex.rs_data     = rs_data;
        o_id_ex.rt_data     = rt_data;
        // Logical immediates take zero extension
        o_id_ex.imm_ext     = wb_ctrl.zero_extend ? {{(`DATA_W-16){1'b0}}, imm}
                                                  : {{(`DATA_W-16){imm[15]}}, imm};
        o_id_ex.jump_target = {i_pc4[`DATA_W-1 -: 4], i_instr[25:0], 2'b00};
        o_id_ex.rs          = rs;
        o_id_ex.rt          = rt;
        o_id_ex.rd          = rd;
        o_id_ex.ex          = ex_ctrl;
        o_id_ex.mem         = mem_ctrl;
        o_id_ex.wb          = wb_ctrl;
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module execute_stage
(
    input  mips_pkg::id_ex_t         i_id_ex,
    output logic [`DATA_W-1:0]       o_alu_result,
    output logic [`DATA_W-1:0]       o_store_data,
    output logic [`REG_ADDR_W-1:0]   o_write_reg,
    output logic                     o_reg_write,
    output logic                     o_mem_read,
    output logic                     o_mem_write,
    output logic                     o_mem_to_reg,
    output logic                     o_branch_taken,
    output logic [`DATA_W-1:0]       o_branch_target,
    output logic                     o_jump,
    output logic [`DATA_W-1:0]       o_jump_target,
    output logic                     o_halt
);

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_PASSB
    } alu_fn_e;

    alu_fn_e            alu_fn;
    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] alu_out;
    logic               zero;

    // ALU control
    always_comb
    begin
        alu_fn = ALU_ADD;
        case (i_id_ex.ex.alu_op)
            mips_pkg::ALUOP_SUB: alu_fn = ALU_SUB;
            mips_pkg::ALUOP_FUNCT:
            begin
                case (mips_pkg::funct_e'(i_id_ex.instruction[5:0]))
                    mips_pkg::FN_SUB: alu_fn = ALU_SUB;
                    mips_pkg::FN_AND: alu_fn = ALU_AND;
                    mips_pkg::FN_OR:  alu_fn = ALU_OR;
                    mips_pkg::FN_XOR: alu_fn = ALU_XOR;
                    mips_pkg::FN_NOR: alu_fn = ALU_NOR;
                    mips_pkg::FN_SLT: alu_fn = ALU_SLT;
                    default:          alu_fn = ALU_ADD;
                endcase
            end
            mips_pkg::ALUOP_IMM:
            begin
                case (mips_pkg::opcode_e'(i_id_ex.instruction[31:26]))
                    mips_pkg::OP_ANDI: alu_fn = ALU_AND;
                    mips_pkg::OP_ORI:  alu_fn = ALU_OR;
                    mips_pkg::OP_SLTI: alu_fn = ALU_SLT;
                    mips_pkg::OP_LUI:  alu_fn = ALU_PASSB;
                    default:           alu_fn = ALU_ADD;
                endcase
            end
            default: alu_fn = ALU_ADD;
        endcase
    end

    assign op_a = i_id_ex.rs_data;

    // LUI feeds the immediate already moved to the upper half
    always_comb
    begin
        if (i_id_ex.wb.lui)
            op_b = {i_id_ex.imm_ext[15:0], 16'h0000};
        else if (i_id_ex.ex.alu_src)
            op_b = i_id_ex.imm_ext;
        else
            op_b = i_id_ex.rt_data;
    end

    always_comb
    begin
        case (alu_fn)
            ALU_SUB:   alu_out = op_a - op_b;
            ALU_AND:   alu_out = op_a & op_b;
            ALU_OR:    alu_out = op_a | op_b;
            ALU_XOR:   alu_out = op_a ^ op_b;
            ALU_NOR:   alu_out = ~(op_a | op_b);
            ALU_SLT:   alu_out = {{(`DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASSB: alu_out = op_b;
            default:   alu_out = op_a + op_b;
        endcase
    end

    assign zero = (alu_out == '0);

    // JAL returns PC+8
    assign o_alu_result = i_id_ex.ex.jal ? (i_id_ex.pc4 + `DATA_W'd4) : alu_out;
    assign o_store_data = i_id_ex.rt_data;

    always_comb
    begin
        if (i_id_ex.ex.jal)
            o_write_reg = '1;
        else if (i_id_ex.ex.reg_dst)
            o_write_reg = i_id_ex.rd;
        else
            o_write_reg = i_id_ex.rt;
    end

    assign o_reg_write     = i_id_ex.wb.reg_write;
    assign o_mem_read      = i_id_ex.mem.mem_read;
    assign o_mem_write     = i_id_ex.mem.mem_write;
    assign o_mem_to_reg    = i_id_ex.wb.mem_to_reg;
    assign o_branch_taken  = (i_id_ex.mem.branch && zero) || (i_id_ex.mem.nbranch && !zero);
    assign o_branch_target = i_id_ex.pc4 + {i_id_ex.imm_ext[`DATA_W-3:0], 2'b00};
    assign o_jump          = i_id_ex.ex.jump;
    assign o_jump_target   = i_id_ex.jump_target;
    assign o_halt          = i_id_ex.wb.halt;

    always_comb
    begin
        a_mem_excl: assert (!(i_id_ex.mem.mem_read && i_id_ex.mem.mem_write))
            else $error("mem_read and mem_write both set");
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
mips_pkg.sv
control_unit.sv
register_file.sv
decode_stage.sv
id_ex_reg.sv
execute_stage.sv
mips_id_ex_top.sv
tb_checker.sv
tb_top.sv

// ==== id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
(
    input  wire              i_clk,
    input  wire              i_rst,
    input  wire              i_flush,
    input  mips_pkg::id_ex_t i_id_ex,
    output mips_pkg::id_ex_t o_id_ex
);

    mips_pkg::id_ex_t stage_q;

    always_ff @(posedge i_clk)
    begin
        // Flush turns the slot into a bubble
        if (i_rst || i_flush)
        begin
            stage_q <= '0;
        end
        else
        begin
            stage_q <= i_id_ex;
        end
    end

    assign o_id_ex = stage_q;

    a_flush_bubble: assert property (@(posedge i_clk)
        i_flush |=> ({o_id_ex.ex, o_id_ex.mem, o_id_ex.wb} == '0));

endmodule

`default_nettype wire

// ==== mips_id_ex_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module mips_id_ex_top
(
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_flush,
    input  wire [`DATA_W-1:0]       i_instr,
    input  wire [`DATA_W-1:0]       i_pc4,
    input  wire                     i_wb_en,
    input  wire [`REG_ADDR_W-1:0]   i_wb_addr,
    input  wire [`DATA_W-1:0]       i_wb_data,
    output logic [`DATA_W-1:0]      o_alu_result,
    output logic [`DATA_W-1:0]      o_store_data,
    output logic [`REG_ADDR_W-1:0]  o_write_reg,
    output logic                    o_reg_write,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic                    o_mem_to_reg,
    output logic                    o_branch_taken,
    output logic [`DATA_W-1:0]      o_branch_target,
    output logic                    o_jump,
    output logic [`DATA_W-1:0]      o_jump_target,
    output logic                    o_halt
);

    mips_pkg::id_ex_t id_ex_d;
    mips_pkg::id_ex_t id_ex_q;

    decode_stage u_decode_stage
    (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_instr   (i_instr),
        .i_pc4     (i_pc4),
        .i_wb_en   (i_wb_en),
        .i_wb_addr (i_wb_addr),
        .i_wb_data (i_wb_data),
        .o_id_ex   (id_ex_d)
    );

    id_ex_reg u_id_ex_reg
    (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_flush (i_flush),
        .i_id_ex (id_ex_d),
        .o_id_ex (id_ex_q)
    );

    execute_stage u_execute_stage
    (
        .i_id_ex         (id_ex_q),
        .o_alu_result    (o_alu_result),
        .o_store_data    (o_store_data),
        .o_write_reg     (o_write_reg),
        .o_reg_write     (o_reg_write),
        .o_mem_read      (o_mem_read),
        .o_mem_write     (o_mem_write),
        .o_mem_to_reg    (o_mem_to_reg),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_jump          (o_jump),
        .o_jump_target   (o_jump_target),
        .o_halt          (o_halt)
    );

endmodule

`default_nettype wire

// ==== mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Data path and register index widths
`define DATA_W     32
`define REG_ADDR_W 5

`endif

// ==== mips_pkg.sv ====
`default_nettype none

`include "mips_params.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011,
        OP_HALT  = 6'b111111
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_XOR = 6'b100110,
        FN_NOR = 6'b100111,
        FN_SLT = 6'b101010
    } funct_e;

    // IMM defers to the opcode in the ALU control
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,
        ALUOP_SUB   = 2'b01,
        ALUOP_FUNCT = 2'b10,
        ALUOP_IMM   = 2'b11
    } alu_op_e;

    typedef struct packed {
        logic    jump;
        logic    jal;
        logic    alu_src;
        alu_op_e alu_op;
        logic    reg_dst;
    } ex_ctrl_t;

    typedef struct packed {
        logic branch;
        logic nbranch;
        logic mem_write;
        logic mem_read;
    } mem_ctrl_t;

    typedef struct packed {
        logic mem_to_reg;
        logic reg_write;
        logic zero_extend;
        logic lui;
        logic halt;
    } wb_ctrl_t;

    // PC+8 is rebuilt from pc4 in execute
    typedef struct packed {
        logic [`DATA_W-1:0]     pc4;
        logic [`DATA_W-1:0]     instruction;
        logic [`DATA_W-1:0]     rs_data;
        logic [`DATA_W-1:0]     rt_data;
        logic [`DATA_W-1:0]     imm_ext;
        logic [`DATA_W-1:0]     jump_target;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        ex_ctrl_t               ex;
        mem_ctrl_t              mem;
        wb_ctrl_t               wb;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module register_file
(
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire [`REG_ADDR_W-1:0]  i_rs_addr,
    input  wire [`REG_ADDR_W-1:0]  i_rt_addr,
    input  wire                    i_wr_en,
    input  wire [`REG_ADDR_W-1:0]  i_wr_addr,
    input  wire [`DATA_W-1:0]      i_wr_data,
    output logic [`DATA_W-1:0]     o_rs_data,
    output logic [`DATA_W-1:0]     o_rt_data
);

    logic [`DATA_W-1:0] regs [0:(1 << `REG_ADDR_W)-1];
    logic               wr_live;

    // Register 0 never takes a write
    assign wr_live = i_wr_en && (i_wr_addr != '0);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < (1 << `REG_ADDR_W); i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_live)
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Write-through for a same-cycle read
    assign o_rs_data = (wr_live && (i_wr_addr == i_rs_addr)) ? i_wr_data : regs[i_rs_addr];
    assign o_rt_data = (wr_live && (i_wr_addr == i_rt_addr)) ? i_wr_data : regs[i_rt_addr];

    a_wr_addr_known: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wr_en |-> !$isunknown(i_wr_addr));

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module tb_checker
(
    input  wire                    i_clk,
    input  wire                    i_exp_valid,
    input  wire [`DATA_W-1:0]      i_exp_result,
    input  wire [`REG_ADDR_W-1:0]  i_exp_write_reg,
    input  wire [6:0]              i_exp_flags,
    input  wire [1:0]              i_exp_tsel,
    input  wire [`DATA_W-1:0]      i_exp_target,
    input  wire [`DATA_W-1:0]      i_exp_store,
    input  wire [`DATA_W-1:0]      i_alu_result,
    input  wire [`DATA_W-1:0]      i_store_data,
    input  wire [`REG_ADDR_W-1:0]  i_write_reg,
    input  wire                    i_reg_write,
    input  wire                    i_mem_read,
    input  wire                    i_mem_write,
    input  wire                    i_mem_to_reg,
    input  wire                    i_branch_taken,
    input  wire [`DATA_W-1:0]      i_branch_target,
    input  wire                    i_jump,
    input  wire [`DATA_W-1:0]      i_jump_target,
    input  wire                    i_halt,
    output int                     o_checks,
    output int                     o_errors
);

    logic                   valid_q = 1'b0;
    logic [`DATA_W-1:0]     result_q;
    logic [`REG_ADDR_W-1:0] write_reg_q;
    logic [6:0]             flags_q;
    logic [1:0]             tsel_q;
    logic [`DATA_W-1:0]     target_q;
    logic [`DATA_W-1:0]     store_q;
    int                     check_count = 0;
    int                     err_count = 0;

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp)
        begin
            $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
            err_count++;
        end
    endtask

    // Expected values line up with the DUT one edge later
    always @(posedge i_clk)
    begin
        valid_q     <= i_exp_valid;
        result_q    <= i_exp_result;
        write_reg_q <= i_exp_write_reg;
        flags_q     <= i_exp_flags;
        tsel_q      <= i_exp_tsel;
        target_q    <= i_exp_target;
        store_q     <= i_exp_store;
    end

    // Outputs settle well before the falling edge
    always @(negedge i_clk)
    begin
        if (valid_q)
        begin
            compare_field("o_alu_result", result_q, i_alu_result);
            compare_field("o_write_reg", 32'(write_reg_q), 32'(i_write_reg));
            compare_field("o_reg_write", 32'(flags_q[6]), 32'(i_reg_write));
            compare_field("o_mem_read", 32'(flags_q[5]), 32'(i_mem_read));
            compare_field("o_mem_write", 32'(flags_q[4]), 32'(i_mem_write));
            compare_field("o_mem_to_reg", 32'(flags_q[3]), 32'(i_mem_to_reg));
            compare_field("o_branch_taken", 32'(flags_q[2]), 32'(i_branch_taken));
            compare_field("o_jump", 32'(flags_q[1]), 32'(i_jump));
            compare_field("o_halt", 32'(flags_q[0]), 32'(i_halt));
            case (tsel_q)
                2'd1: compare_field("o_branch_target", target_q, i_branch_target);
                2'd2: compare_field("o_jump_target", target_q, i_jump_target);
                default: ;
            endcase
            // Store data only matters on stores
            if (flags_q[4])
                compare_field("o_store_data", store_q, i_store_data);
            check_count++;
        end
    end

    assign o_checks = check_count;
    assign o_errors = err_count;

endmodule

`default_nettype wire

// ==== tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module tb_top;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_ROWS     = 32;
    localparam int WAIT_LIMIT   = 50;

    // Flag bit order is reg_write, mem_read, mem_write, mem_to_reg, taken, jump, halt
    localparam logic [6:0] F_RW  = 7'b1000000;
    localparam logic [6:0] F_MR  = 7'b0100000;
    localparam logic [6:0] F_MW  = 7'b0010000;
    localparam logic [6:0] F_M2R = 7'b0001000;
    localparam logic [6:0] F_BT  = 7'b0000100;
    localparam logic [6:0] F_JMP = 7'b0000010;
    localparam logic [6:0] F_HLT = 7'b0000001;

    localparam logic [1:0] T_NONE = 2'd0;
    localparam logic [1:0] T_BR   = 2'd1;
    localparam logic [1:0] T_JMP  = 2'd2;

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_flush;
    logic [`DATA_W-1:0]     i_instr;
    logic [`DATA_W-1:0]     i_pc4;
    logic                   i_wb_en;
    logic [`REG_ADDR_W-1:0] i_wb_addr;
    logic [`DATA_W-1:0]     i_wb_data;
    logic [`DATA_W-1:0]     o_alu_result;
    logic [`DATA_W-1:0]     o_store_data;
    logic [`REG_ADDR_W-1:0] o_write_reg;
    logic                   o_reg_write;
    logic                   o_mem_read;
    logic                   o_mem_write;
    logic                   o_mem_to_reg;
    logic                   o_branch_taken;
    logic [`DATA_W-1:0]     o_branch_target;
    logic                   o_jump;
    logic [`DATA_W-1:0]     o_jump_target;
    logic                   o_halt;

    logic                   exp_valid;
    logic [`DATA_W-1:0]     exp_result;
    logic [`REG_ADDR_W-1:0] exp_write_reg;
    logic [6:0]             exp_flags;
    logic [1:0]             exp_tsel;
    logic [`DATA_W-1:0]     exp_target;
    logic [`DATA_W-1:0]     exp_store;

    // Stimulus and expectation table
    logic                   tab_wb_en     [MAX_ROWS];
    logic [`REG_ADDR_W-1:0] tab_wb_addr   [MAX_ROWS];
    logic [`DATA_W-1:0]     tab_wb_data   [MAX_ROWS];
    logic [`DATA_W-1:0]     tab_instr     [MAX_ROWS];
    logic [`DATA_W-1:0]     tab_pc4       [MAX_ROWS];
    logic                   tab_flush     [MAX_ROWS];
    logic [`DATA_W-1:0]     tab_result    [MAX_ROWS];
    logic [`REG_ADDR_W-1:0] tab_write_reg [MAX_ROWS];
    logic [6:0]             tab_flags     [MAX_ROWS];
    logic [1:0]             tab_tsel      [MAX_ROWS];
    logic [`DATA_W-1:0]     tab_target    [MAX_ROWS];
    logic [`DATA_W-1:0]     tab_store     [MAX_ROWS];

    int                     n_rows;
    int                     checks;
    int                     errors;
    int                     wait_cycles;
    logic                   timed_out;
    integer                 seed;
    logic [`DATA_W-1:0]     a;
    logic [`DATA_W-1:0]     b;
    logic [`DATA_W-1:0]     c;

    mips_id_ex_top i_mips_id_ex_top
    (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_flush         (i_flush),
        .i_instr         (i_instr),
        .i_pc4           (i_pc4),
        .i_wb_en         (i_wb_en),
        .i_wb_addr       (i_wb_addr),
        .i_wb_data       (i_wb_data),
        .o_alu_result    (o_alu_result),
        .o_store_data    (o_store_data),
        .o_write_reg     (o_write_reg),
        .o_reg_write     (o_reg_write),
        .o_mem_read      (o_mem_read),
        .o_mem_write     (o_mem_write),
        .o_mem_to_reg    (o_mem_to_reg),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_jump          (o_jump),
        .o_jump_target   (o_jump_target),
        .o_halt          (o_halt)
    );

    tb_checker u_tb_checker
    (
        .i_clk           (i_clk),
        .i_exp_valid     (exp_valid),
        .i_exp_result    (exp_result),
        .i_exp_write_reg (exp_write_reg),
        .i_exp_flags     (exp_flags),
        .i_exp_tsel      (exp_tsel),
        .i_exp_target    (exp_target),
        .i_exp_store     (exp_store),
        .i_alu_result    (o_alu_result),
        .i_store_data    (o_store_data),
        .i_write_reg     (o_write_reg),
        .i_reg_write     (o_reg_write),
        .i_mem_read      (o_mem_read),
        .i_mem_write     (o_mem_write),
        .i_mem_to_reg    (o_mem_to_reg),
        .i_branch_taken  (o_branch_taken),
        .i_branch_target (o_branch_target),
        .i_jump          (o_jump),
        .i_jump_target   (o_jump_target),
        .i_halt          (o_halt),
        .o_checks        (checks),
        .o_errors        (errors)
    );

    always #20 i_clk = ~i_clk;

    function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {6'b000000, rs, rt, rd, 5'b00000, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic logic [31:0] slt(input logic [31:0] x, input logic [31:0] y);
        return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    endfunction

    // Targets use the pc4 of the row being built
    function automatic logic [31:0] br_target(input logic [15:0] off);
        return tab_pc4[n_rows] + {{14{off[15]}}, off, 2'b00};
    endfunction

    function automatic logic [31:0] jmp_target(input logic [25:0] idx);
        return {tab_pc4[n_rows][31:28], idx, 2'b00};
    endfunction

    task automatic add_row(input logic wb_en, input logic [4:0] wb_addr,
                           input logic [31:0] wb_data, input logic [31:0] instr,
                           input logic flush);
        tab_wb_en[n_rows]   = wb_en;
        tab_wb_addr[n_rows] = wb_addr;
        tab_wb_data[n_rows] = wb_data;
        tab_instr[n_rows]   = instr;
        tab_pc4[n_rows]     = 32'h9000_0104 + 4 * n_rows;
        tab_flush[n_rows]   = flush;
    endtask

    task automatic set_expect(input logic [31:0] result, input logic [4:0] write_reg,
                              input logic [6:0] flags, input logic [1:0] tsel,
                              input logic [31:0] target, input logic [31:0] store);
        tab_result[n_rows]    = result;
        tab_write_reg[n_rows] = write_reg;
        tab_flags[n_rows]     = flags;
        tab_tsel[n_rows]      = tsel;
        tab_target[n_rows]    = target;
        tab_store[n_rows]     = store;
        n_rows++;
    endtask

    task automatic apply_row(input int k);
        i_wb_en       = tab_wb_en[k];
        i_wb_addr     = tab_wb_addr[k];
        i_wb_data     = tab_wb_data[k];
        i_instr       = tab_instr[k];
        i_pc4         = tab_pc4[k];
        i_flush       = tab_flush[k];
        exp_valid     = 1'b1;
        exp_result    = tab_result[k];
        exp_write_reg = tab_write_reg[k];
        exp_flags     = tab_flags[k];
        exp_tsel      = tab_tsel[k];
        exp_target    = tab_target[k];
        exp_store     = tab_store[k];
    endtask

    initial
    begin
        i_clk     = 1'b0;
        i_rst     = 1'b1;
        i_flush   = 1'b0;
        i_instr   = '0;
        i_pc4     = '0;
        i_wb_en   = 1'b0;
        i_wb_addr = '0;
        i_wb_data = '0;
        // During reset every output is expected at zero
        exp_valid     = 1'b1;
        exp_result    = '0;
        exp_write_reg = '0;
        exp_flags     = '0;
        exp_tsel      = T_NONE;
        exp_target    = '0;
        exp_store     = '0;
        timed_out     = 1'b0;

        seed = 32'h9894;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        if (b == a)
            b = ~a;
        n_rows = 0;

        // R-type rows where the first two read through a same-cycle write
        add_row(1'b1, 5'd1, a, enc_r(mips_pkg::FN_ADD, 5'd1, 5'd0, 5'd3), 1'b0);
        set_expect(a, 5'd3, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b1, 5'd2, b, enc_r(mips_pkg::FN_SUB, 5'd1, 5'd2, 5'd4), 1'b0);
        set_expect(a - b, 5'd4, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_r(mips_pkg::FN_AND, 5'd1, 5'd2, 5'd5), 1'b0);
        set_expect(a & b, 5'd5, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_r(mips_pkg::FN_OR, 5'd1, 5'd2, 5'd6), 1'b0);
        set_expect(a | b, 5'd6, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_r(mips_pkg::FN_XOR, 5'd1, 5'd2, 5'd7), 1'b0);
        set_expect(a ^ b, 5'd7, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_r(mips_pkg::FN_NOR, 5'd1, 5'd2, 5'd8), 1'b0);
        set_expect(~(a | b), 5'd8, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_r(mips_pkg::FN_SLT, 5'd1, 5'd2, 5'd9), 1'b0);
        set_expect(slt(a, b), 5'd9, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_r(mips_pkg::FN_SLT, 5'd2, 5'd1, 5'd10), 1'b0);
        set_expect(slt(b, a), 5'd10, F_RW, T_NONE, 32'd0, 32'd0);

        // Immediates
        add_row(1'b0, 5'd0, 32'd0, enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd11, 16'hFFF0), 1'b0);
        set_expect(a + 32'hFFFF_FFF0, 5'd11, F_RW, T_NONE, 32'd0, 32'd0);
        // Zero operand tells sign extension apart from zero extension
        add_row(1'b0, 5'd0, 32'd0, enc_i(mips_pkg::OP_SLTI, 5'd0, 5'd12, 16'h8000), 1'b0);
        set_expect(slt(32'd0, 32'hFFFF_8000), 5'd12, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_i(mips_pkg::OP_ANDI, 5'd1, 5'd13, 16'hF0F0), 1'b0);
        set_expect(a & 32'h0000_F0F0, 5'd13, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_i(mips_pkg::OP_ORI, 5'd2, 5'd14, 16'h8001), 1'b0);
        set_expect(b | 32'h0000_8001, 5'd14, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_i(mips_pkg::OP_LUI, 5'd0, 5'd15, 16'hABCD), 1'b0);
        set_expect(32'hABCD_0000, 5'd15, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b1, 5'd0, c, enc_r(mips_pkg::FN_ADD, 5'd0, 5'd0, 5'd16), 1'b0);
        set_expect(32'd0, 5'd16, F_RW, T_NONE, 32'd0, 32'd0);

        // Loads and stores
        add_row(1'b0, 5'd0, 32'd0, enc_i(mips_pkg::OP_LW, 5'd1, 5'd17, 16'h0010), 1'b0);
        set_expect(a + 32'd16, 5'd17, F_RW | F_MR | F_M2R, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_i(mips_pkg::OP_SW, 5'd1, 5'd2, 16'hFFFC), 1'b0);
        set_expect(a + 32'hFFFF_FFFC, 5'd2, F_MW, T_NONE, 32'd0, b);

        // Branches, jumps and halt
        add_row(1'b0, 5'd0, 32'd0, enc_i(mips_pkg::OP_BEQ, 5'd1, 5'd1, 16'd5), 1'b0);
        set_expect(32'd0, 5'd1, F_BT, T_BR, br_target(16'd5), 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_i(mips_pkg::OP_BEQ, 5'd1, 5'd2, 16'hFFFD), 1'b0);
        set_expect(a - b, 5'd2, 7'd0, T_BR, br_target(16'hFFFD), 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_i(mips_pkg::OP_BNE, 5'd1, 5'd2, 16'd7), 1'b0);
        set_expect(a - b, 5'd2, F_BT, T_BR, br_target(16'd7), 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_i(mips_pkg::OP_BNE, 5'd2, 5'd2, 16'd1), 1'b0);
        set_expect(32'd0, 5'd2, 7'd0, T_BR, br_target(16'd1), 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_j(mips_pkg::OP_J, 26'h000_0123), 1'b0);
        set_expect(32'd0, 5'd0, F_JMP, T_JMP, jmp_target(26'h000_0123), 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_j(mips_pkg::OP_JAL, 26'h000_0456), 1'b0);
        set_expect(tab_pc4[n_rows] + 32'd4, 5'd31, F_RW | F_JMP, T_JMP,
                   jmp_target(26'h000_0456), 32'd0);

        // Flushed row becomes a bubble and the next one runs normally
        add_row(1'b0, 5'd0, 32'd0, enc_r(mips_pkg::FN_ADD, 5'd1, 5'd2, 5'd18), 1'b1);
        set_expect(32'd0, 5'd0, 7'd0, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_r(mips_pkg::FN_ADD, 5'd1, 5'd2, 5'd18), 1'b0);
        set_expect(a + b, 5'd18, F_RW, T_NONE, 32'd0, 32'd0);
        add_row(1'b0, 5'd0, 32'd0, enc_j(mips_pkg::OP_HALT, 26'd0), 1'b0);
        set_expect(32'd0, 5'd0, F_HLT, T_NONE, 32'd0, 32'd0);

        repeat (RESET_CYCLES) @(posedge i_clk);
        #2;
        i_rst = 1'b0;
        apply_row(0);
        for (int k = 1; k < n_rows; k++)
        begin
            @(posedge i_clk);
            #2;
            apply_row(k);
        end
        @(posedge i_clk);
        #2;
        i_wb_en   = 1'b0;
        i_instr   = '0;
        i_flush   = 1'b0;
        exp_valid = 1'b0;

        wait_cycles = 0;
        while ((checks < RESET_CYCLES + n_rows) && (wait_cycles < WAIT_LIMIT))
        begin
            @(posedge i_clk);
            wait_cycles++;
        end
        if (checks < RESET_CYCLES + n_rows)
        begin
            timed_out = 1'b1;
            $display("Timed out waiting for the checker to finish the last row");
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (timed_out || (errors != 0))
            $display("TEST FAILED");
        else
            $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
